/* design/denseNode.sv */
`timescale 1ns/10ps

module denseNode (
	input logic clk,
	input logic rstN,
	input logic inValid,
	input nodePkg::floatWord inData,
	output logic outValid,
	output nodePkg::floatWord nodeOut
);
	import nodePkg::*;

	logic pushValid;
	floatWord pushData;
	logic pushLast;
	logic pop;
	floatWord popData;
	logic popLast;
	logic empty;

	productStage producer (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.inData(inData),
		.pushValid(pushValid),
		.pushData(pushData),
		.pushLast(pushLast)
	);

	productFifo buffer (
		.clk(clk),
		.rstN(rstN),
		.push(pushValid),
		.pushData(pushData),
		.pushLast(pushLast),
		.pop(pop),
		.popData(popData),
		.popLast(popLast),
		.empty(empty)
	);

	nodeAccumulator consumer (
		.clk(clk),
		.rstN(rstN),
		.empty(empty),
		.popData(popData),
		.popLast(popLast),
		.pop(pop),
		.outValid(outValid),
		.nodeOut(nodeOut)
	);

endmodule

/* design/floatAdd.sv */
`timescale 1ns/10ps

module floatAdd (
	input nodePkg::floatWord a,
	input nodePkg::floatWord b,
	output nodePkg::floatWord sum
);
	import nodePkg::*;

	floatWord bigOp;
	floatWord smallOp;
	logic [MantWidth:0] sigBig;
	logic [MantWidth:0] sigSmall;
	logic [MantWidth:0] sigAligned;
	logic [ExpWidth-1:0] expDiff;
	logic [MantWidth+1:0] sigSum;
	logic [MantWidth:0] sigNorm;
	logic [ExpWidth+1:0] expOut;
	int unsigned lzc;

	always_comb
	begin
		// Magnitude order follows the raw bits without the sign
		if (a.bits[FloatWidth-2:0] >= b.bits[FloatWidth-2:0])
		begin
			bigOp = a;
			smallOp = b;
		end
		else
		begin
			bigOp = b;
			smallOp = a;
		end

		// Denormals flushed here
		sigBig = (bigOp.f.exponent == '0) ? '0 : {1'b1, bigOp.f.mantissa};
		sigSmall = (smallOp.f.exponent == '0) ? '0 : {1'b1, smallOp.f.mantissa};

		expDiff = bigOp.f.exponent - smallOp.f.exponent;
		sigAligned = sigSmall >> expDiff; // Shifted-out bits dropped

		if (bigOp.f.sign == smallOp.f.sign)
			sigSum = {1'b0, sigBig} + {1'b0, sigAligned};
		else
			sigSum = {1'b0, sigBig} - {1'b0, sigAligned};

		// Highest set bit wins
		lzc = MantWidth + 1;
		for (int i = 0; i <= MantWidth; i++)
			if (sigSum[i])
				lzc = MantWidth - i;

		if (sigSum[MantWidth+1])
		begin
			sigNorm = sigSum[MantWidth+1:1]; // Carry out
			expOut = {2'b00, bigOp.f.exponent} + 1'b1;
		end
		else
		begin
			sigNorm = sigSum[MantWidth:0] << lzc;
			expOut = {2'b00, bigOp.f.exponent} - lzc[ExpWidth+1:0];
		end

		if (!sigNorm[MantWidth] || expOut[ExpWidth+1] || expOut == '0)
			sum.bits = '0; // Cancellation or underflow
		else
		begin
			sum.f.sign = bigOp.f.sign;
			sum.f.exponent = expOut[ExpWidth-1:0];
			sum.f.mantissa = sigNorm[MantWidth-1:0];
		end
	end

endmodule

/* design/floatMult.sv */
`timescale 1ns/10ps

module floatMult (
	input nodePkg::floatWord a,
	input nodePkg::floatWord b,
	output nodePkg::floatWord product
);
	import nodePkg::*;

	logic [MantWidth:0] sigA;
	logic [MantWidth:0] sigB;
	logic [2*MantWidth+1:0] sigProd;
	logic [ExpWidth+1:0] expSum;
	logic [ExpWidth+1:0] expNorm;

	always_comb
	begin
		sigA = {1'b1, a.f.mantissa};
		sigB = {1'b1, b.f.mantissa};
		sigProd = sigA * sigB;
		// Two spare bits catch the underflow borrow
		expSum = {2'b00, a.f.exponent} + {2'b00, b.f.exponent} - {2'b00, ExpBias};

		product.f.sign = a.f.sign ^ b.f.sign;
		if (sigProd[2*MantWidth+1])
		begin
			expNorm = expSum + 1'b1; // Product in [2,4)
			product.f.mantissa = sigProd[2*MantWidth:MantWidth+1];
		end
		else
		begin
			expNorm = expSum;
			product.f.mantissa = sigProd[2*MantWidth-1:MantWidth];
		end
		product.f.exponent = expNorm[ExpWidth-1:0];

		// Zero or denormal operand, or result below the normal range
		if (a.f.exponent == '0 || b.f.exponent == '0 || expNorm[ExpWidth+1] || expNorm == '0)
			product.bits = '0;
	end

endmodule

/* design/nodeAccumulator.sv */
`timescale 1ns/10ps

module nodeAccumulator (
	input logic clk,
	input logic rstN,
	input logic empty,
	input nodePkg::floatWord popData,
	input logic popLast,
	output logic pop,
	output logic outValid,
	output nodePkg::floatWord nodeOut
);
	import nodePkg::*;

	logic biasCycle;
	floatWord acc;
	floatWord addend;
	floatWord sum;

	assign pop = !empty;
	assign addend = biasCycle ? NodeBias : popData; // Adder shared with the bias step

	floatAdd adder (
		.a(acc),
		.b(addend),
		.sum(sum)
	);

	always_ff @(posedge clk or negedge rstN)
		if (!rstN)
		begin
			biasCycle <= 1'b0;
			acc <= '0;
			outValid <= 1'b0;
		end
		else
		begin
			outValid <= biasCycle;
			if (biasCycle)
			begin
				// Next vector starts from zero, so its first product loads as is
				acc <= pop ? popData : '0;
				biasCycle <= pop && popLast;
			end
			else if (pop)
			begin
				acc <= sum;
				biasCycle <= popLast;
			end
		end

	// Rectifier
	always_ff @(posedge clk)
		if (biasCycle)
			nodeOut <= sum.f.sign ? '0 : sum;

	singlePulse: assert property (@(posedge clk) disable iff (!rstN)
		outValid |=> !outValid);

endmodule

/* design/nodePkg.sv */
package nodePkg;

	localparam int FloatWidth = 32;
	localparam int ExpWidth = 8;
	localparam int MantWidth = 23;
	localparam logic [ExpWidth-1:0] ExpBias = 8'd127;

	typedef struct packed
	{
		logic sign;
		logic [ExpWidth-1:0] exponent;
		logic [MantWidth-1:0] mantissa;
	} floatFields;

	// Same word, raw or split into IEEE-754 fields
	typedef union packed
	{
		logic [FloatWidth-1:0] bits;
		floatFields f;
	} floatWord;

	localparam int NumInputs = 15;
	localparam int IndexWidth = 4;

	// Trained weights, activation 0 first
	localparam floatWord NodeWeights [NumInputs] = '{
		32'h3E09AF8A, // 0.134
		32'h3F62F2EE, // 0.886
		32'h3FAF5ED4, // 1.37
		32'hBC2FB101, // -0.0107
		32'h3E8FE9DC,
		32'h3E0FA049,
		32'h3F15AF6D,
		32'hBE8CA5AA,
		32'hBE5DC3DB,
		32'h3F4D6B13,
		32'h3F8AB2B4,
		32'h3E9F8150,
		32'hBD591BAA,
		32'h3DE1BC50,
		32'hBF4B1C1D  // -0.793, outweighs the bias
	};

	localparam floatWord NodeBias = 32'h3EA20CAB; // 0.316

	localparam int FifoDepth = 4;
	localparam int FifoAddrWidth = 2;

endpackage

/* design/productFifo.sv */
`timescale 1ns/10ps

module productFifo (
	input logic clk,
	input logic rstN,
	input logic push,
	input nodePkg::floatWord pushData,
	input logic pushLast,
	input logic pop,
	output nodePkg::floatWord popData,
	output logic popLast,
	output logic empty
);
	import nodePkg::*;

	floatWord dataMem [FifoDepth];
	logic lastMem [FifoDepth];
	logic [FifoAddrWidth-1:0] rdPtr;
	logic [FifoAddrWidth-1:0] wrPtr;
	logic [FifoAddrWidth:0] count;
	logic full;

	// An incoming product passes straight through when nothing is stored
	assign empty = (count == '0) && !push;
	assign full = count[FifoAddrWidth]; // Depth is a power of two
	assign popData = (count == '0) ? pushData : dataMem[rdPtr];
	assign popLast = (count == '0) ? pushLast : lastMem[rdPtr];

	always_ff @(posedge clk)
		if (push)
		begin
			dataMem[wrPtr] <= pushData;
			lastMem[wrPtr] <= pushLast;
		end

	always_ff @(posedge clk or negedge rstN)
		if (!rstN)
		begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end

	noOverflow: assert property (@(posedge clk) disable iff (!rstN) push |-> !full);
	noUnderflow: assert property (@(posedge clk) disable iff (!rstN) pop |-> !empty);

endmodule

/* design/productStage.sv */
`timescale 1ns/10ps

module productStage (
	input logic clk,
	input logic rstN,
	input logic inValid,
	input nodePkg::floatWord inData,
	output logic pushValid,
	output nodePkg::floatWord pushData,
	output logic pushLast
);
	import nodePkg::*;

	logic [IndexWidth-1:0] index;
	logic indexLast;
	floatWord product;

	assign indexLast = index == IndexWidth'(NumInputs - 1);

	floatMult mult (
		.a(inData),
		.b(NodeWeights[index]),
		.product(product)
	);

	always_ff @(posedge clk or negedge rstN)
		if (!rstN)
		begin
			index <= '0;
			pushValid <= 1'b0;
			pushLast <= 1'b0;
		end
		else
		begin
			pushValid <= inValid;
			if (inValid)
			begin
				pushLast <= indexLast;
				index <= indexLast ? '0 : index + 1'b1; // Wrap after activation 14
			end
		end

	always_ff @(posedge clk)
		if (inValid)
			pushData <= product;

	indexRange: assert property (@(posedge clk) disable iff (!rstN)
		index <= IndexWidth'(NumInputs - 1));

endmodule

/* filelist.f */
+incdir+verification
design/nodePkg.sv
design/floatMult.sv
design/floatAdd.sv
design/productStage.sv
design/productFifo.sv
design/nodeAccumulator.sv
design/denseNode.sv
verification/denseNodeTb.sv

/* run.sh */
#!/bin/sh
# Build and run the denseNode testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module denseNodeTb \
	-Mdir obj_dir -o simv -f filelist.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* verification/nodeRefModel.svh */
// Truncating single-precision multiply, denormal inputs flushed
function automatic floatWord modelMult(input floatWord x, input floatWord y);
	floatWord r;
	logic [2*MantWidth+1:0] sig;
	int e;
	r.bits = '0;
	if (x.f.exponent == '0 || y.f.exponent == '0)
		return r;
	sig = {{(MantWidth+1){1'b0}}, 1'b1, x.f.mantissa} * {{(MantWidth+1){1'b0}}, 1'b1, y.f.mantissa};
	e = int'(x.f.exponent) + int'(y.f.exponent) - int'(ExpBias);
	if (sig[2*MantWidth+1])
	begin
		sig = sig >> 1;
		e++;
	end
	if (e <= 0)
		return r; // Underflow
	r.f.sign = x.f.sign ^ y.f.sign;
	r.f.exponent = e[ExpWidth-1:0];
	r.f.mantissa = sig[2*MantWidth-1:MantWidth];
	return r;
endfunction

// Truncating add, smaller operand aligned to the larger
function automatic floatWord modelAdd(input floatWord x, input floatWord y);
	floatWord hi;
	floatWord lo;
	floatWord r;
	logic [MantWidth:0] mHi;
	logic [MantWidth:0] mLo;
	logic [MantWidth+1:0] s;
	int e;
	int shift;
	r.bits = '0;
	hi = (x.bits[FloatWidth-2:0] >= y.bits[FloatWidth-2:0]) ? x : y;
	lo = (x.bits[FloatWidth-2:0] >= y.bits[FloatWidth-2:0]) ? y : x;
	mHi = (hi.f.exponent == '0) ? '0 : {1'b1, hi.f.mantissa};
	mLo = (lo.f.exponent == '0) ? '0 : {1'b1, lo.f.mantissa};
	shift = int'(hi.f.exponent) - int'(lo.f.exponent);
	mLo = (shift > MantWidth) ? '0 : mLo >> shift;
	if (hi.f.sign == lo.f.sign)
		s = {1'b0, mHi} + {1'b0, mLo};
	else
		s = {1'b0, mHi} - {1'b0, mLo};
	if (s == '0)
		return r; // Exact cancellation
	e = int'(hi.f.exponent);
	if (s[MantWidth+1])
	begin
		s = s >> 1;
		e++;
	end
	while (!s[MantWidth])
	begin
		s = s << 1;
		e--;
	end
	if (e <= 0)
		return r;
	r.f.sign = hi.f.sign;
	r.f.exponent = e[ExpWidth-1:0];
	r.f.mantissa = s[MantWidth-1:0];
	return r;
endfunction

function automatic floatWord modelNode(input floatWord acts [NumInputs]);
	floatWord total;
	total = '0;
	for (int i = 0; i < NumInputs; i++)
		total = modelAdd(total, modelMult(acts[i], NodeWeights[i])); // Input order
	total = modelAdd(total, NodeBias);
	if (total.f.sign)
		total = '0; // Rectifier
	return total;
endfunction

/* verification/denseNodeTb.sv */
`timescale 1ns/10ps

module denseNodeTb;
	import nodePkg::*;

	`include "nodeRefModel.svh"

	localparam int TimeoutCycles = 40 * 20 + 50;
	localparam int DrainCycles = 20;
	localparam floatWord One = 32'h3F800000;

	logic clk = 1'b0;
	logic rstN;
	logic inValid;
	floatWord inData;
	logic outValid;
	floatWord nodeOut;

	floatWord expQueue [$];
	floatWord headResult;
	string testName = "reset";
	int valueErrors = 0;
	int protocolErrors = 0;
	int cycleCount = 0;

	denseNode DUT (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.inData(inData),
		.outValid(outValid),
		.nodeOut(nodeOut)
	);

	always #4 clk = ~clk;

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= TimeoutCycles)
		begin
			$display("Timeout: run hung after %0d cycles in test %s", cycleCount, testName);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	task automatic checkFloat(input floatWord expected, input floatWord actual);
		if (actual.bits !== expected.bits)
		begin
			$display("[ERROR] %s: expected %h, actual %h", testName, expected.bits, actual.bits);
			valueErrors++;
		end
	endtask

	task automatic checkCycles(input int expected, input int actual);
		if (actual != expected)
		begin
			$display("[ERROR] %s: expected %0d cycles, actual %0d cycles", testName, expected,
				actual);
			valueErrors++;
		end
	endtask

	task automatic checkSilent(input bit unexpectedPulse, input int missing);
		if (unexpectedPulse)
		begin
			$display("Test %s: outValid pulsed while no result was expected", testName);
			protocolErrors++;
		end
		if (missing != 0)
		begin
			$display("Test %s: %0d expected results never arrived", testName, missing);
			protocolErrors++;
		end
	endtask

	// Outputs settle half a cycle after the edge
	always @(negedge clk)
		if (outValid)
		begin
			if (expQueue.size() == 0)
				checkSilent(1'b1, 0);
			else
			begin
				headResult = expQueue.pop_front();
				checkFloat(headResult, nodeOut);
			end
		end

	function automatic void randomVector(output floatWord acts [NumInputs]);
		for (int i = 0; i < NumInputs; i++)
		begin
			acts[i].f.sign = 1'($urandom_range(1, 0));
			acts[i].f.exponent = 8'($urandom_range(134, 120));
			acts[i].f.mantissa = 23'($urandom());
		end
	endfunction

	task automatic driveCycle(input logic valid, input floatWord value);
		inValid = valid;
		inData = value;
		@(posedge clk);
		#1;
	endtask

	task automatic streamVector(input floatWord acts [NumInputs], input floatWord expected,
		input int maxGap);
		int gap;
		expQueue.push_back(expected);
		for (int i = 0; i < NumInputs; i++)
		begin
			gap = (i == 0) ? 0 : int'($urandom_range(maxGap, 0));
			repeat (gap) driveCycle(1'b0, '0);
			driveCycle(1'b1, acts[i]);
		end
	endtask

	task automatic drainResults();
		int waited;
		waited = 0;
		while (expQueue.size() != 0 && waited < DrainCycles)
		begin
			driveCycle(1'b0, '0);
			waited++;
		end
		repeat (2) driveCycle(1'b0, '0); // Late pulses
		checkSilent(1'b0, expQueue.size());
		expQueue.delete();
	endtask

	task automatic zeroVector();
		floatWord acts [NumInputs];
		testName = "zeroVector";
		foreach (acts[i])
			acts[i] = '0;
		streamVector(acts, NodeBias, 0);
		drainResults();
	endtask

	task automatic oneHotSweep();
		floatWord acts [NumInputs];
		testName = "oneHotSweep";
		for (int hot = 0; hot < NumInputs; hot++)
		begin
			foreach (acts[i])
				acts[i] = '0;
			acts[hot] = One;
			streamVector(acts, modelNode(acts), 0);
		end
		drainResults();
	endtask

	task automatic isolatedLatency();
		floatWord acts [NumInputs];
		int cycles;
		testName = "isolatedLatency";
		randomVector(acts);
		repeat (4) driveCycle(1'b0, '0);
		streamVector(acts, modelNode(acts), 0);
		inValid = 1'b0;
		cycles = 0; // Cycle 0 carried activation 14
		while (!outValid && cycles < DrainCycles)
		begin
			@(negedge clk);
			cycles++;
		end
		@(posedge clk);
		#1;
		checkCycles(3, cycles);
		drainResults();
	endtask

	task automatic backToBack();
		floatWord acts [NumInputs];
		testName = "backToBack";
		repeat (8)
		begin
			randomVector(acts);
			streamVector(acts, modelNode(acts), 0);
		end
		drainResults();
	endtask

	task automatic gappedVectors();
		floatWord acts [NumInputs];
		testName = "gappedVectors";
		repeat (3)
		begin
			randomVector(acts);
			streamVector(acts, modelNode(acts), 3);
		end
		drainResults();
	endtask

	task automatic resetMidVector();
		floatWord acts [NumInputs];
		testName = "resetMidVector";
		randomVector(acts);
		for (int i = 0; i < 7; i++)
			driveCycle(1'b1, acts[i]);
		inValid = 1'b0;
		rstN = 1'b0;
		repeat (3) driveCycle(1'b0, '0);
		rstN = 1'b1;
		repeat (2) driveCycle(1'b0, '0);
		randomVector(acts);
		streamVector(acts, modelNode(acts), 0);
		drainResults();
	endtask

	initial
	begin
		void'($urandom(32'ha2ca));
		rstN = 1'b0;
		inValid = 1'b0;
		inData = '0;
		repeat (16) @(posedge clk);
		#1;
		rstN = 1'b1;
		zeroVector();
		oneHotSweep();
		isolatedLatency();
		backToBack();
		gappedVectors();
		resetMidVector();
		$display("Errors: %0d value, %0d protocol", valueErrors, protocolErrors);
		if (valueErrors == 0 && protocolErrors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule
